/* bridgeCases.txt */
// op 1 host packet: 1 flags n word[n] r reply[r], flags bit0 = bad checksum
// op 2 bus push / op 3 bus expect: op ch n word[n]; op 4 stall, 5 reset count, 6 idle, 0 end
0004 0000
0001 0000 0005 AB02 0003 1111 2222 3333 0000
0003 0000 0003 1111 2222 3333
0006 000A
0003 0001 0000
0001 0001 0004 AC02 0002 5555 6666 0000
0006 000A
0003 0001 0000
0001 0000 0002 AC03 0000 0005 AC03 0003 0000 0000 0001
0002 0000 0004 A001 A002 A003 A004
0001 0000 0002 AB04 0002 0004 AB04 0002 A001 A002
0001 0000 0002 AB04 0005 0004 AB04 0002 A003 A004
0002 0000 0003 B001 B002 B003
0001 0000 0002 AB03 0000 0005 AB03 0003 0003 0000 0000
0001 0000 0002 AB04 0003 0005 AB04 0003 B001 B002 B003
0001 0000 0004 CD02 0002 7777 8888 0000
0001 0000 0002 CD04 0001 0000
0006 000A
0003 0000 0000
0003 0001 0000
0005 0000
0001 0000 0002 AB01 0000 0000
0005 0001
0004 0001
0001 0000 0005 AB02 0003 1111 2222 3333 0000
0003 0000 0003 1111 2222 3333
0002 0000 0004 A001 A002 A003 A004
0001 0000 0002 AB04 0002 0004 AB04 0002 A001 A002
0001 0000 0002 AB04 0005 0004 AB04 0002 A003 A004
0004 0000
0006 000A
0003 0001 0000
0005 0001
0000

/* flist.f */
bridgeTypesPkg.sv
protocolPkg.sv
bufCtrlIf.sv
packetBuffer.sv
hostFramer.sv
commandDispatch.sv
bridgeTop.sv
tb_bridgeTop.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_bridgeTop -f flist.f -o tb_bridgeTop
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_bridgeTop > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
	exit 1
fi
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi
exit 0

/* tb_bridgeTop.sv */
////////////////////////////////////////
// bridge testbench driven by the case file
////////////////////////////////////////

`timescale 1ns/1ps

module tb_bridgeTop
	import bridgeTypesPkg::*, protocolPkg::*;
();

	localparam int MEM_WORDS = 512;
	localparam int CYCLES_PER_CASE = 200;

	logic clk;
	logic arstN;
	logic hostInValid;
	logic hostInReady;
	wordT hostInData;
	logic hostInLast;
	logic hostOutValid;
	logic hostOutReady;
	wordT hostOutData;
	logic hostOutLast;
	logic bus0InValid;
	logic bus0InReady;
	wordT bus0InData;
	logic bus1InValid;
	logic bus1InReady;
	wordT bus1InData;
	logic bus0OutValid;
	logic bus0OutReady;
	wordT bus0OutData;
	logic bus1OutValid;
	logic bus1OutReady;
	wordT bus1OutData;
	logic resetRequest;

	wordT caseMem [MEM_WORDS];
	wordT replyQ [$];  // every accepted reply word
	logic lastQ [$];
	wordT bus0Q [$];
	wordT bus1Q [$];
	int   replyRd;     // words already compared
	int   bus0Rd;
	int   bus1Rd;
	int   resetPulses;
	int   cycles;
	int   cycleLimit;
	bit   stallOn;

	bridgeTop #(
		.blockAddr0(8'hAB),
		.blockAddr1(8'hAC),
		.bufDepth(16)
	) u_bridgeTop (.*);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// ready signals drop at random while stalling
	initial begin
		void'($urandom(404));
		hostOutReady = 1'b1;
		bus0OutReady = 1'b1;
		bus1OutReady = 1'b1;
		forever begin
			@(posedge clk);
			if (stallOn) begin
				hostOutReady <= ($urandom % 4) != 0;
				bus0OutReady <= ($urandom % 3) != 0;
				bus1OutReady <= ($urandom % 3) != 0;
			end else begin
				hostOutReady <= 1'b1;
				bus0OutReady <= 1'b1;
				bus1OutReady <= 1'b1;
			end
		end
	end

	// collect everything the DUT hands out
	always @(posedge clk) begin
		if (arstN) begin
			if (hostOutValid && hostOutReady) begin
				replyQ.push_back(hostOutData);
				lastQ.push_back(hostOutLast);
			end
			if (bus0OutValid && bus0OutReady)
				bus0Q.push_back(bus0OutData);
			if (bus1OutValid && bus1OutReady)
				bus1Q.push_back(bus1OutData);
			if (resetRequest)
				resetPulses++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycleLimit) begin
			$display("timeout: no progress within %0d cycles", cycleLimit);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end
	end

	task automatic checkWord(input wordT got, input wordT exp, input string what);
		if (got !== exp) begin
			$display("FAIL @%0t: %s got %h expected %h", $time, what, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic checkCmd(input cmdCodeT got, input cmdCodeT exp, input string what);
		if (got !== exp) begin
			$display("FAIL @%0t: %s got %h expected %h", $time, what, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "command mismatch");
		end
	endtask

	task automatic checkSize(input pktSizeT got, input pktSizeT exp, input string what);
		if (got !== exp) begin
			$display("FAIL @%0t: %s got %0d expected %0d", $time, what, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "size mismatch");
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAIL @%0t: %s got %b expected %b", $time, what, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "flag mismatch");
		end
	endtask

	// wrapping sum over header, size and data
	function automatic wordT packetSum(input int base, input int n);
		wordT sum;
		sum = '0;
		for (int i = 0; i < n; i++)
			sum = sum + caseMem[base + i];
		return sum;
	endfunction

	function automatic int recordLen(input int pc);
		int n;
		n = int'(caseMem[pc + 2]);
		case (caseMem[pc])
			16'h0001: return 4 + n + int'(caseMem[pc + 3 + n]);
			16'h0002, 16'h0003: return 3 + n;
			default: return 2;
		endcase
	endfunction

	function automatic int busAvail(input int ch);
		return (ch == 0) ? bus0Q.size() - bus0Rd : bus1Q.size() - bus1Rd;
	endfunction

	task automatic hostWord(input wordT w, input logic last);
		hostInValid <= 1'b1;
		hostInData  <= w;
		hostInLast  <= last;
		do
			@(posedge clk);
		while (!hostInReady);
	endtask

	task automatic hostPacket(input int pc);
		int   n;
		int   r;
		wordT sum;
		wordT got;
		wordT exp;
		n = int'(caseMem[pc + 2]);
		r = int'(caseMem[pc + 3 + n]);
		sum = packetSum(pc + 3, n);
		if (caseMem[pc + 1][0])
			sum = sum + 16'h0001; // corrupt it
		for (int i = 0; i < n; i++)
			hostWord(caseMem[pc + 3 + i], 1'b0);
		hostWord(sum, 1'b1);
		hostInValid <= 1'b0;
		hostInLast  <= 1'b0;
		// framer accepts input again once its reply is out
		do
			@(posedge clk);
		while (!hostInReady);
		checkWord(wordT'(replyQ.size() - replyRd), wordT'(r), "reply length");
		for (int i = 0; i < r; i++) begin
			got = replyQ[replyRd + i];
			exp = caseMem[pc + 4 + n + i];
			if (i == 0) begin
				checkWord(wordT'(got[15:8]), wordT'(exp[15:8]), "reply address");
				checkCmd(cmdCodeT'(got[7:0]), cmdCodeT'(exp[7:0]), "reply command");
			end else if (i == 1) begin
				checkSize(pktSizeT'(got), pktSizeT'(exp), "reply size");
			end else begin
				checkWord(got, exp, "reply data");
			end
			checkFlag(lastQ[replyRd + i], (i == r - 1), "reply last");
		end
		replyRd = replyRd + r;
	endtask

	task automatic busPush(input int pc);
		int ch;
		int n;
		ch = int'(caseMem[pc + 1]);
		n  = int'(caseMem[pc + 2]);
		for (int i = 0; i < n; i++) begin
			if (ch == 0) begin
				bus0InValid <= 1'b1;
				bus0InData  <= caseMem[pc + 3 + i];
			end else begin
				bus1InValid <= 1'b1;
				bus1InData  <= caseMem[pc + 3 + i];
			end
			do
				@(posedge clk);
			while (!((ch == 0) ? bus0InReady : bus1InReady));
		end
		bus0InValid <= 1'b0;
		bus1InValid <= 1'b0;
	endtask

	task automatic busExpect(input int pc);
		int ch;
		int n;
		ch = int'(caseMem[pc + 1]);
		n  = int'(caseMem[pc + 2]);
		while (busAvail(ch) < n)
			@(posedge clk);
		checkWord(wordT'(busAvail(ch)), wordT'(n), "bus word count");
		for (int i = 0; i < n; i++) begin
			if (ch == 0)
				checkWord(bus0Q[bus0Rd + i], caseMem[pc + 3 + i], "bus0 word");
			else
				checkWord(bus1Q[bus1Rd + i], caseMem[pc + 3 + i], "bus1 word");
		end
		if (ch == 0)
			bus0Rd = bus0Rd + n;
		else
			bus1Rd = bus1Rd + n;
	endtask

	initial begin
		int pc;
		int records;
		arstN       = 1'b0;
		hostInValid = 1'b0;
		hostInData  = '0;
		hostInLast  = 1'b0;
		bus0InValid = 1'b0;
		bus0InData  = '0;
		bus1InValid = 1'b0;
		bus1InData  = '0;
		$readmemh("bridgeCases.txt", caseMem);
		pc = 0;
		records = 0;
		while (caseMem[pc] != 16'h0000) begin
			records++;
			pc = pc + recordLen(pc);
		end
		cycleLimit = CYCLES_PER_CASE * (records + 1);
		if (records == 0) begin
			$display("case file bridgeCases.txt is missing or empty");
			$display("=== FAIL ===");
			$fatal(1, "no cases");
		end
		repeat (3) @(posedge clk);
		arstN <= 1'b1;
		pc = 0;
		while (caseMem[pc] != 16'h0000) begin
			case (caseMem[pc])
				16'h0001: hostPacket(pc);
				16'h0002: busPush(pc);
				16'h0003: busExpect(pc);
				16'h0004: stallOn <= caseMem[pc + 1][0];
				16'h0005: checkWord(wordT'(resetPulses), caseMem[pc + 1], "reset pulses");
				16'h0006: repeat (int'(caseMem[pc + 1])) @(posedge clk);
				default: begin
					$display("unknown opcode %h at case word %0d", caseMem[pc], pc);
					$display("=== FAIL ===");
					$fatal(1, "bad case file");
				end
			endcase
			pc = pc + recordLen(pc);
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* bridgeTop.sv */
////////////////////////////////////////
// bridge core with two bus channels
////////////////////////////////////////

`timescale 1ns/1ps

module bridgeTop import bridgeTypesPkg::*, protocolPkg::*; #(
	parameter blockAddrT blockAddr0 = 8'hAB,
	parameter blockAddrT blockAddr1 = 8'hAC,
	parameter int        bufDepth   = 16
) (
	input  logic clk,
	input  logic arstN,
	input  logic hostInValid,
	output logic hostInReady,
	input  wordT hostInData,
	input  logic hostInLast,
	output logic hostOutValid,
	input  logic hostOutReady,
	output wordT hostOutData,
	output logic hostOutLast,
	input  logic bus0InValid,
	output logic bus0InReady,
	input  wordT bus0InData,
	input  logic bus1InValid,
	output logic bus1InReady,
	input  wordT bus1InData,
	output logic bus0OutValid,
	input  logic bus0OutReady,
	output wordT bus0OutData,
	output logic bus1OutValid,
	input  logic bus1OutReady,
	output wordT bus1OutData,
	output logic resetRequest
);

	bufCtrlIf tx0Ctrl ();
	bufCtrlIf tx1Ctrl ();
	bufCtrlIf rx0Ctrl ();
	bufCtrlIf rx1Ctrl ();

	// framer to dispatcher
	logic      hdrStrobe, payValid, payReady, pktEnd, pktErr;
	blockAddrT hdrAddr, replyAddr;
	cmdCodeT   hdrCmd, replyCmd;
	pktSizeT   hdrSize, replySize;
	wordT      payData, replyData;
	logic      replyStart, replyValid, replyReady, replyLast;

	// buffer side streams
	logic tx0Valid, tx0Ready, tx1Valid, tx1Ready;
	logic rx0Valid, rx0Ready, rx1Valid, rx1Ready;
	logic rx0WrValid, rx0WrReady, rx1WrValid, rx1WrReady;
	wordT tx0Data, tx1Data, rx0Data, rx1Data, rx0WrData, rx1WrData;

	hostFramer framer (.*);

	commandDispatch #(
		.blockAddr0(blockAddr0),
		.blockAddr1(blockAddr1)
	) dispatch (.*);

	// tx buffers drain straight onto the bus
	packetBuffer #(.bufDepth(bufDepth)) txBuf0 (
		.clk, .arstN, .ctrl(tx0Ctrl),
		.inValid(tx0Valid), .inReady(tx0Ready), .inData(tx0Data),
		.outValid(bus0OutValid), .outReady(bus0OutReady), .outData(bus0OutData)
	);
	packetBuffer #(.bufDepth(bufDepth)) txBuf1 (
		.clk, .arstN, .ctrl(tx1Ctrl),
		.inValid(tx1Valid), .inReady(tx1Ready), .inData(tx1Data),
		.outValid(bus1OutValid), .outReady(bus1OutReady), .outData(bus1OutData)
	);

	packetBuffer #(.bufDepth(bufDepth)) rxBuf0 (
		.clk, .arstN, .ctrl(rx0Ctrl),
		.inValid(rx0WrValid), .inReady(rx0WrReady), .inData(rx0WrData),
		.outValid(rx0Valid), .outReady(rx0Ready), .outData(rx0Data)
	);
	packetBuffer #(.bufDepth(bufDepth)) rxBuf1 (
		.clk, .arstN, .ctrl(rx1Ctrl),
		.inValid(rx1WrValid), .inReady(rx1WrReady), .inData(rx1WrData),
		.outValid(rx1Valid), .outReady(rx1Ready), .outData(rx1Data)
	);

endmodule

/* commandDispatch.sv */
////////////////////////////////////////
// command decode, data routing, replies
////////////////////////////////////////

`timescale 1ns/1ps

module commandDispatch import bridgeTypesPkg::*, protocolPkg::*; #(
	parameter blockAddrT blockAddr0 = 8'hAB,
	parameter blockAddrT blockAddr1 = 8'hAC
) (
	input  logic          clk,
	input  logic          arstN,
	input  logic          hdrStrobe,
	input  blockAddrT     hdrAddr,
	input  cmdCodeT       hdrCmd,
	input  pktSizeT       hdrSize,
	input  logic          payValid,
	output logic          payReady,
	input  wordT          payData,
	input  logic          pktEnd,
	input  logic          pktErr,
	output logic          replyStart,
	output blockAddrT     replyAddr,
	output cmdCodeT       replyCmd,
	output pktSizeT       replySize,
	output logic          replyValid,
	input  logic          replyReady,
	output wordT          replyData,
	output logic          replyLast,
	bufCtrlIf.controller  tx0Ctrl,
	bufCtrlIf.controller  tx1Ctrl,
	bufCtrlIf.controller  rx0Ctrl,
	bufCtrlIf.controller  rx1Ctrl,
	output logic          tx0Valid,
	input  logic          tx0Ready,
	output wordT          tx0Data,
	output logic          tx1Valid,
	input  logic          tx1Ready,
	output wordT          tx1Data,
	input  logic          rx0Valid,
	output logic          rx0Ready,
	input  wordT          rx0Data,
	input  logic          rx1Valid,
	output logic          rx1Ready,
	input  wordT          rx1Data,
	input  logic          bus0InValid,
	output logic          bus0InReady,
	input  wordT          bus0InData,
	input  logic          bus1InValid,
	output logic          bus1InReady,
	input  wordT          bus1InData,
	output logic          rx0WrValid,
	input  logic          rx0WrReady,
	output wordT          rx0WrData,
	output logic          rx1WrValid,
	input  logic          rx1WrReady,
	output wordT          rx1WrData,
	output logic          resetRequest
);

	typedef enum logic [1:0] {dsIdle, dsStart, dsStream} dispStateT;

	dispStateT state;
	cmdCodeT   cmdQ;      // command of the current packet
	logic      chQ;
	pktSizeT   reqSizeQ;
	logic      goodQ;     // checksum result
	pktSizeT   remainQ;
	logic [1:0] stsIdx;
	wordT      stsSnap [STATUS_WORDS];
	fillT      errCnt [2];
	fillT      txUsed [2];
	fillT      rxUsed [2];
	wordT      rxData [2];
	logic [1:0] rxValid;
	logic [1:0] txOpen;
	logic [1:0] txSel;
	logic      hit0, hit1, decCh, replyOn, stsQ, replyFire;
	cmdCodeT   decCmd;

	assign txUsed[0] = tx0Ctrl.used;
	assign txUsed[1] = tx1Ctrl.used;
	assign rxUsed[0] = rx0Ctrl.used;
	assign rxUsed[1] = rx1Ctrl.used;
	assign rxData[0] = rx0Data;
	assign rxData[1] = rx1Data;
	assign rxValid   = {rx1Valid, rx0Valid};

	// decode on the header strobe, unknown address drops the packet
	assign hit0   = (hdrAddr == blockAddr0);
	assign hit1   = (hdrAddr == blockAddr1);
	assign decCh  = hit1 && !hit0;
	assign decCmd = (hit0 || hit1) ? hdrCmd : cmdUnknown;

	assign txOpen[0] = hdrStrobe && (decCmd == cmdSendData) && !decCh;
	assign txOpen[1] = hdrStrobe && (decCmd == cmdSendData) && decCh;
	assign txSel[0]  = (cmdQ == cmdSendData) && !chQ;
	assign txSel[1]  = (cmdQ == cmdSendData) && chQ;

	assign tx0Ctrl.open     = txOpen[0];
	assign tx0Ctrl.commit   = pktEnd && txSel[0];
	assign tx0Ctrl.rollback = pktErr && txSel[0];
	assign tx1Ctrl.open     = txOpen[1];
	assign tx1Ctrl.commit   = pktEnd && txSel[1];
	assign tx1Ctrl.rollback = pktErr && txSel[1];
	assign tx0Valid = payValid && txSel[0];
	assign tx1Valid = payValid && txSel[1];
	assign tx0Data  = payData;
	assign tx1Data  = payData;
	assign payReady = txSel[0] ? tx0Ready : (txSel[1] ? tx1Ready : 1'b1); // others sink

	// each bus word is its own committed transfer
	assign rx0WrValid  = bus0InValid;
	assign rx0WrData   = bus0InData;
	assign bus0InReady = rx0WrReady;
	assign rx0Ctrl.open     = bus0InValid && rx0WrReady;
	assign rx0Ctrl.commit   = bus0InValid && rx0WrReady;
	assign rx0Ctrl.rollback = 1'b0;
	assign rx1WrValid  = bus1InValid;
	assign rx1WrData   = bus1InData;
	assign bus1InReady = rx1WrReady;
	assign rx1Ctrl.open     = bus1InValid && rx1WrReady;
	assign rx1Ctrl.commit   = bus1InValid && rx1WrReady;
	assign rx1Ctrl.rollback = 1'b0;

	// reply header
	assign stsQ       = (cmdQ == cmdReceiveSts);
	assign replyOn    = goodQ && (stsQ || cmdQ == cmdReceiveData);
	assign replyStart = (state == dsStart);
	assign replyAddr  = chQ ? blockAddr1 : blockAddr0;
	assign replyCmd   = replyOn ? cmdQ : cmdUnknown;

	always_comb begin
		if (!replyOn)
			replySize = '0;
		else if (stsQ)
			replySize = pktSizeT'(STATUS_WORDS);
		else if (fillT'(reqSizeQ) < rxUsed[chQ])
			replySize = reqSizeQ;
		else
			replySize = pktSizeT'(rxUsed[chQ]);
	end

	// reply words from the rx buffer or the status snapshot
	assign replyValid = (state == dsStream) && (stsQ || rxValid[chQ]);
	assign replyData  = stsQ ? stsSnap[stsIdx] : rxData[chQ];
	assign replyLast  = (remainQ == 8'd1);
	assign replyFire  = replyValid && replyReady;
	assign rx0Ready   = (state == dsStream) && !stsQ && !chQ && replyReady;
	assign rx1Ready   = (state == dsStream) && !stsQ && chQ && replyReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state        <= dsIdle;
			cmdQ         <= cmdUnknown;
			chQ          <= 1'b0;
			reqSizeQ     <= '0;
			goodQ        <= 1'b0;
			remainQ      <= '0;
			stsIdx       <= '0;
			errCnt       <= '{default: '0};
			resetRequest <= 1'b0;
		end else begin
			resetRequest <= pktEnd && (cmdQ == cmdReset);
			if (hdrStrobe) begin
				cmdQ     <= decCmd;
				chQ      <= decCh;
				reqSizeQ <= hdrSize;
			end
			for (int i = 0; i < 2; i++)
				errCnt[i] <= errCnt[i] + fillT'(pktErr && txSel[i]);
			case (state)
				dsIdle: if (pktEnd || pktErr) begin
					goodQ <= pktEnd;
					state <= dsStart;
				end
				dsStart: begin
					remainQ <= replySize;
					stsIdx  <= '0;
					state   <= (replySize != '0) ? dsStream : dsIdle;
				end
				dsStream: if (replyFire) begin
					remainQ <= remainQ - 1'b1;
					if (replyLast)
						state <= dsIdle;
					else
						stsIdx <= stsIdx + 1'b1;
				end
				default: state <= dsIdle;
			endcase
		end
	end

	// status is frozen when the reply starts
	always_ff @(posedge clk) begin
		if (state == dsStart) begin
			stsSnap[0] <= wordT'(rxUsed[chQ]);
			stsSnap[1] <= wordT'(txUsed[chQ]);
			stsSnap[2] <= wordT'(errCnt[chQ]);
		end
	end

	// framer holds new requests back until the reply is out
	assert property (@(posedge clk) disable iff (!arstN)
		hdrStrobe |-> (state == dsIdle))
		else $error("commandDispatch: header during reply");

endmodule

/* hostFramer.sv */
////////////////////////////////////////
// host packet parser and reply serializer
////////////////////////////////////////

`timescale 1ns/1ps

module hostFramer import bridgeTypesPkg::*, protocolPkg::*; (
	input  logic      clk,
	input  logic      arstN,
	input  logic      hostInValid,
	output logic      hostInReady,
	input  wordT      hostInData,
	input  logic      hostInLast,
	output logic      hostOutValid,
	input  logic      hostOutReady,
	output wordT      hostOutData,
	output logic      hostOutLast,
	output logic      hdrStrobe,
	output blockAddrT hdrAddr,
	output cmdCodeT   hdrCmd,
	output pktSizeT   hdrSize,
	output logic      payValid,
	input  logic      payReady,
	output wordT      payData,
	output logic      pktEnd,
	output logic      pktErr,
	input  logic      replyStart,
	input  blockAddrT replyAddr,
	input  cmdCodeT   replyCmd,
	input  pktSizeT   replySize,
	input  logic      replyValid,
	output logic      replyReady,
	input  wordT      replyData,
	input  logic      replyLast
);

	typedef enum logic [2:0] {
		stHeader, stSize, stPayload, stChecksum,
		stWait, stReplyHdr, stReplySize, stReplyData
	} frameStateT;

	frameStateT state;
	wordT      hdrWordQ;
	wordT      sumQ;     // running checksum
	pktSizeT   payCntQ;
	blockAddrT rAddrQ;
	cmdCodeT   rCmdQ;
	pktSizeT   rSizeQ;
	logic      inFire;
	logic      outFire;

	assign hostInReady = (state == stHeader) || (state == stSize) || (state == stChecksum)
		|| ((state == stPayload) && payReady);
	assign inFire = hostInValid && hostInReady;

	// header goes out together with the size word
	assign hdrStrobe = (state == stSize) && inFire;
	assign hdrAddr   = hdrWordQ[HDR_ADDR_LSB +: HDR_ADDR_W];
	assign hdrCmd    = toCmd(hdrWordQ[HDR_CMD_LSB +: HDR_CMD_W]);
	assign hdrSize   = pktSizeT'(hostInData);
	assign payValid  = (state == stPayload) && hostInValid;
	assign payData   = hostInData;
	assign pktEnd    = (state == stChecksum) && inFire && (hostInData == sumQ);
	assign pktErr    = (state == stChecksum) && inFire && (hostInData != sumQ);

	always_comb begin
		hostOutValid = 1'b0;
		hostOutData  = '0;
		hostOutLast  = 1'b0;
		replyReady   = 1'b0;
		case (state)
			stReplyHdr: begin
				hostOutValid = 1'b1;
				hostOutData[HDR_ADDR_LSB +: HDR_ADDR_W] = rAddrQ;
				hostOutData[HDR_CMD_LSB +: HDR_CMD_W]   = rCmdQ;
			end
			stReplySize: begin
				hostOutValid = 1'b1;
				hostOutData  = wordT'(rSizeQ);
				hostOutLast  = (rSizeQ == '0); // empty reply ends here
			end
			stReplyData: begin
				hostOutValid = replyValid;
				hostOutData  = replyData;
				hostOutLast  = replyLast;
				replyReady   = hostOutReady;
			end
			default: ;
		endcase
	end

	assign outFire = hostOutValid && hostOutReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state   <= stHeader;
			sumQ    <= '0;
			payCntQ <= '0;
		end else begin
			case (state)
				stHeader: if (inFire) begin
					sumQ  <= hostInData;
					state <= stSize;
				end
				stSize: if (inFire) begin
					sumQ    <= sumQ + hostInData;
					payCntQ <= hdrSize;
					// only send data carries payload words
					state   <= (hdrCmd == cmdSendData && hdrSize != '0) ? stPayload : stChecksum;
				end
				stPayload: if (inFire) begin
					sumQ    <= sumQ + hostInData;
					payCntQ <= payCntQ - 1'b1;
					if (payCntQ == 8'd1)
						state <= stChecksum;
				end
				stChecksum: if (inFire)
					state <= stWait;
				stWait: if (replyStart)
					state <= (replyCmd == cmdUnknown) ? stHeader : stReplyHdr; // no reply
				stReplyHdr: if (outFire)
					state <= stReplySize;
				stReplySize: if (outFire)
					state <= (rSizeQ == '0) ? stHeader : stReplyData;
				stReplyData: if (outFire && replyLast)
					state <= stHeader;
				default: state <= stHeader;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == stHeader) && inFire)
			hdrWordQ <= hostInData;
		if ((state == stWait) && replyStart) begin
			rAddrQ <= replyAddr;
			rCmdQ  <= replyCmd;
			rSizeQ <= replySize;
		end
	end

	// host framing and the parser agree on where a packet ends
	assert property (@(posedge clk) disable iff (!arstN)
		inFire |-> (hostInLast == (state == stChecksum)))
		else $error("hostFramer: last flag not on checksum word");

endmodule

/* packetBuffer.sv */
////////////////////////////////////////
// ring buffer with tentative writes
////////////////////////////////////////

`timescale 1ns/1ps

module packetBuffer import bridgeTypesPkg::*; #(
	parameter int bufDepth = 16
) (
	input  logic           clk,
	input  logic           arstN,
	bufCtrlIf.buffer       ctrl,
	input  logic           inValid,
	output logic           inReady,
	input  wordT           inData,
	output logic           outValid,
	input  logic           outReady,
	output wordT           outData
);

	localparam int PTR_W = (bufDepth > 1) ? $clog2(bufDepth) : 1;
	typedef logic [PTR_W-1:0] ptrT;

	wordT mem [bufDepth];
	ptrT  rdPtr;
	ptrT  wrPtr;
	ptrT  savedPtr;   // write pointer at open
	fillT used;       // committed, unread
	fillT total;      // committed plus tentative
	fillT pending;    // written since open
	fillT pendingNext;
	logic opened;
	logic wrEn;
	logic rdEn;

	function automatic ptrT nextPtr(input ptrT p);
		return (p == ptrT'(bufDepth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign inReady  = (total != fillT'(bufDepth));
	assign wrEn     = inValid && inReady;
	assign outValid = (used != '0);
	assign rdEn     = outValid && outReady;
	assign outData  = mem[rdPtr]; // head word, no read latency
	assign ctrl.used = used;

	// an open in the same cycle restarts the count
	assign pendingNext = (ctrl.open ? '0 : pending) + fillT'(wrEn);

	always_ff @(posedge clk) begin
		if (wrEn)
			mem[wrPtr] <= inData;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rdPtr    <= '0;
			wrPtr    <= '0;
			savedPtr <= '0;
			used     <= '0;
			total    <= '0;
			pending  <= '0;
			opened   <= 1'b0;
		end else begin
			if (rdEn)
				rdPtr <= nextPtr(rdPtr);
			if (ctrl.open)
				savedPtr <= wrPtr;
			if (ctrl.rollback)
				wrPtr <= savedPtr;
			else if (wrEn)
				wrPtr <= nextPtr(wrPtr);

			total <= total + fillT'(wrEn) - fillT'(rdEn)
				- (ctrl.rollback ? pendingNext : '0);
			used <= used - fillT'(rdEn) + (ctrl.commit ? pendingNext : '0);
			pending <= (ctrl.commit || ctrl.rollback) ? '0 : pendingNext;
			opened <= (opened || ctrl.open) && !(ctrl.commit || ctrl.rollback);
		end
	end

	// transaction must be open before it is closed
	assert property (@(posedge clk) disable iff (!arstN)
		(ctrl.commit || ctrl.rollback) |-> (opened || ctrl.open))
		else $error("packetBuffer: commit or rollback without open");

	// never written past full
	assert property (@(posedge clk) disable iff (!arstN)
		(total <= fillT'(bufDepth)) && (used <= total))
		else $error("packetBuffer: fill count out of range");

endmodule

/* bufCtrlIf.sv */
////////////////////////////////////////
// packet buffer transaction control
////////////////////////////////////////

`timescale 1ns/1ps

interface bufCtrlIf import bridgeTypesPkg::*; ();

	logic open;     // save write pointer
	logic commit;   // publish words since open
	logic rollback; // drop words since open
	fillT used;     // committed unread words

	modport controller (
		output open, commit, rollback,
		input  used
	);

	modport buffer (
		input  open, commit, rollback,
		output used
	);

endinterface

/* protocolPkg.sv */
////////////////////////////////////////
// host command codes and header layout
////////////////////////////////////////

package protocolPkg;

	typedef enum logic [7:0] {
		cmdReset       = 8'h01,
		cmdSendData    = 8'h02,
		cmdReceiveSts  = 8'h03,
		cmdReceiveData = 8'h04,
		cmdUnknown     = 8'hFF
	} cmdCodeT;

	// header word: address in the upper byte, command in the lower byte
	localparam int HDR_ADDR_LSB = 8;
	localparam int HDR_ADDR_W   = 8;
	localparam int HDR_CMD_LSB  = 0;
	localparam int HDR_CMD_W    = 8;

	// size word: payload length for send, requested length for receive
	localparam int STATUS_WORDS = 3; // rx fill, tx fill, error count

	// map a raw code onto the enum, anything else is unknown
	function automatic cmdCodeT toCmd(input logic [HDR_CMD_W-1:0] code);
		case (code)
			8'h01:   return cmdReset;
			8'h02:   return cmdSendData;
			8'h03:   return cmdReceiveSts;
			8'h04:   return cmdReceiveData;
			default: return cmdUnknown;
		endcase
	endfunction

endpackage

/* bridgeTypesPkg.sv */
////////////////////////////////////////
// word, address, size and fill types
////////////////////////////////////////

package bridgeTypesPkg;

	// host and bus word
	typedef logic [15:0] wordT;

	// block address from the header
	typedef logic [7:0] blockAddrT;

	// payload word count, also the requested reply length
	typedef logic [7:0] pktSizeT;

	typedef logic [15:0] fillT; // fill counts and error counters

endpackage
